// File: include/wisc_consts.svh
// Data width, register count and instruction field positions for the WISC execute unit
`ifndef WISC_CONSTS_SVH
`define WISC_CONSTS_SVH

`define WISC_WIDTH      16  // Data path width
`define WISC_REGS       8   // Register file depth
`define WISC_REG_BITS   3   // Register index width
`define WISC_SHAMT_BITS 4   // Shift amount width

// Instruction word fields
`define WISC_OP_HI      15  // Major opcode
`define WISC_OP_LO      11
`define WISC_RS_HI      10  // Rs in every format
`define WISC_RS_LO      8
`define WISC_RT_HI      7   // Rt for R, Rd for I1
`define WISC_RT_LO      5
`define WISC_RD_HI      4   // Rd for R
`define WISC_RD_LO      2
`define WISC_FUNCT_HI   1   // R format function
`define WISC_FUNCT_LO   0
`define WISC_IMM5_HI    4   // I1 immediate
`define WISC_IMM8_HI    7   // I2 immediate

`endif

// File: verilog/wiscPkg.sv
// Opcode, ALU operation and shift kind enums for the WISC execute unit
`default_nettype none

package wiscPkg;

    typedef enum logic [4:0] {
        OpAddi     = 5'b01000,
        OpSubi     = 5'b01001,
        OpXori     = 5'b01010,
        OpAndni    = 5'b01011,
        OpSlbi     = 5'b10010,
        OpRoli     = 5'b10100,
        OpSlli     = 5'b10101,
        OpRori     = 5'b10110,
        OpSrli     = 5'b10111,
        OpLbi      = 5'b11000,
        OpBtr      = 5'b11001,
        OpShiftReg = 5'b11010,  // Kind taken from funct
        OpArithReg = 5'b11011,  // Operation taken from funct
        OpSeq      = 5'b11100,
        OpSlt      = 5'b11101,
        OpSle      = 5'b11110,
        OpSco      = 5'b11111
    } opcode_e;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluXor, AluAndn,
        AluShift,
        AluSeq, AluSlt, AluSle, AluSco,
        AluPassB, AluSlbi, AluBtr
    } aluOp_e;

    // Encoding matches the register shift funct field
    typedef enum logic [1:0] {
        ShSll = 2'b00,
        ShSrl = 2'b01,
        ShRol = 2'b10,
        ShRor = 2'b11
    } shiftOp_e;

endpackage

`default_nettype wire

// File: verilog/instrDecode.sv
// Instruction decoder giving register indices, immediate, ALU operation and strobes
`timescale 1ns/1ns
`default_nettype none
`include "wisc_consts.svh"

module instrDecode
    import wiscPkg::*;
(
    input  logic                      instrValid,
    input  logic [`WISC_WIDTH-1:0]    instr,
    output logic [`WISC_REG_BITS-1:0] rdAddrA,
    output logic [`WISC_REG_BITS-1:0] rdAddrB,
    output logic [`WISC_REG_BITS-1:0] dstReg,
    output logic [`WISC_WIDTH-1:0]    imm,
    output logic                      useImm,
    output aluOp_e                    aluOp,
    output shiftOp_e                  shiftOp,
    output logic                      opValid,
    output logic                      illegal
);

    opcode_e                   opcode;
    logic [1:0]                funct;
    logic [`WISC_IMM5_HI:0]    imm5;
    logic [`WISC_IMM8_HI:0]    imm8;
    logic [`WISC_REG_BITS-1:0] rsField;
    logic [`WISC_REG_BITS-1:0] rtField;
    logic [`WISC_REG_BITS-1:0] rdField;
    logic                      known;

    assign opcode  = opcode_e'(instr[`WISC_OP_HI:`WISC_OP_LO]);
    assign funct   = instr[`WISC_FUNCT_HI:`WISC_FUNCT_LO];
    assign imm5    = instr[`WISC_IMM5_HI:0];
    assign imm8    = instr[`WISC_IMM8_HI:0];
    assign rsField = instr[`WISC_RS_HI:`WISC_RS_LO];
    assign rtField = instr[`WISC_RT_HI:`WISC_RT_LO];
    assign rdField = instr[`WISC_RD_HI:`WISC_RD_LO];

    assign rdAddrA = rsField;  // A is always Rs
    assign rdAddrB = rtField;  // Only read for R format

    always_comb begin
        dstReg  = rdField;
        imm     = {{(`WISC_WIDTH-`WISC_IMM5_HI-1){1'b0}}, imm5};
        useImm  = 1'b0;
        aluOp   = AluAdd;
        shiftOp = ShSll;
        known   = 1'b1;
        case (opcode)
            OpAddi, OpSubi: begin
                dstReg = rtField;
                imm    = {{(`WISC_WIDTH-`WISC_IMM5_HI-1){imm5[`WISC_IMM5_HI]}}, imm5};
                useImm = 1'b1;
                aluOp  = (opcode == OpAddi) ? AluAdd : AluSub;
            end
            OpXori, OpAndni: begin
                dstReg = rtField;  // Zero extended imm5
                useImm = 1'b1;
                aluOp  = (opcode == OpXori) ? AluXor : AluAndn;
            end
            OpRoli, OpSlli, OpRori, OpSrli: begin
                dstReg = rtField;
                useImm = 1'b1;
                aluOp  = AluShift;
                case (opcode)
                    OpRoli:  shiftOp = ShRol;
                    OpSlli:  shiftOp = ShSll;
                    OpRori:  shiftOp = ShRor;
                    default: shiftOp = ShSrl;
                endcase
            end
            OpSlbi: begin
                dstReg = rsField;  // Rs is source and destination
                imm    = {{(`WISC_WIDTH-`WISC_IMM8_HI-1){1'b0}}, imm8};
                useImm = 1'b1;
                aluOp  = AluSlbi;
            end
            OpLbi: begin
                dstReg = rsField;
                imm    = {{(`WISC_WIDTH-`WISC_IMM8_HI-1){imm8[`WISC_IMM8_HI]}}, imm8};
                useImm = 1'b1;
                aluOp  = AluPassB;
            end
            OpBtr:      aluOp = AluBtr;
            OpShiftReg: begin
                aluOp   = AluShift;
                shiftOp = shiftOp_e'(funct);
            end
            OpArithReg: begin
                case (funct)
                    2'b00:   aluOp = AluAdd;
                    2'b01:   aluOp = AluSub;
                    2'b10:   aluOp = AluXor;
                    default: aluOp = AluAndn;
                endcase
            end
            OpSeq:   aluOp = AluSeq;
            OpSlt:   aluOp = AluSlt;
            OpSle:   aluOp = AluSle;
            OpSco:   aluOp = AluSco;
            default: known = 1'b0;  // NOP, jumps, branches, memory
        endcase
    end

    assign opValid = instrValid & known;
    assign illegal = instrValid & ~known;

endmodule

`default_nettype wire

// File: verilog/regFile.sv
// Eight-word register file with two bypassed read ports and one write port
`timescale 1ns/1ns
`default_nettype none
`include "wisc_consts.svh"

module regFile (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic [`WISC_REG_BITS-1:0] rdAddrA,
    input  logic [`WISC_REG_BITS-1:0] rdAddrB,
    output logic [`WISC_WIDTH-1:0]    rdDataA,
    output logic [`WISC_WIDTH-1:0]    rdDataB,
    input  logic                      wrEn,
    input  logic [`WISC_REG_BITS-1:0] wrAddr,
    input  logic [`WISC_WIDTH-1:0]    wrData
);

    logic [`WISC_WIDTH-1:0] regs [`WISC_REGS];
    logic                   hitA;
    logic                   hitB;

    // Registers read zero after reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `WISC_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Forward the result still waiting to be written
    assign hitA = wrEn && (wrAddr == rdAddrA);
    assign hitB = wrEn && (wrAddr == rdAddrB);

    assign rdDataA = hitA ? wrData : regs[rdAddrA];
    assign rdDataB = hitB ? wrData : regs[rdAddrB];

endmodule

`default_nettype wire

// File: verilog/barrelShift.sv
// Four-stage logarithmic shifter for logical shifts and rotates
`timescale 1ns/1ns
`default_nettype none
`include "wisc_consts.svh"

module barrelShift
    import wiscPkg::*;
(
    input  logic [`WISC_WIDTH-1:0]      dataIn,
    input  logic [`WISC_SHAMT_BITS-1:0] shamt,
    input  shiftOp_e                    shiftOp,
    output logic [`WISC_WIDTH-1:0]      dataOut
);

    localparam int W = `WISC_WIDTH;

    logic [W-1:0] stage [`WISC_SHAMT_BITS+1];
    logic         isLeft;
    logic         isRot;

    assign isLeft = (shiftOp == ShSll) || (shiftOp == ShRol);
    assign isRot  = (shiftOp == ShRol) || (shiftOp == ShRor);

    assign stage[0] = dataIn;

    for (genvar i = 0; i < `WISC_SHAMT_BITS; i++) begin : gStage
        localparam int N = 1 << i;  // 1, 2, 4, 8

        logic [N-1:0] fillL;
        logic [N-1:0] fillR;

        assign fillL = {N{isRot}} & stage[i][W-1 -: N];  // Wrapped top bits
        assign fillR = {N{isRot}} & stage[i][N-1:0];     // Wrapped low bits

        assign stage[i+1] = !shamt[i] ? stage[i] :
                            isLeft    ? {stage[i][W-N-1:0], fillL} :
                                        {fillR, stage[i][W-1:N]};
    end

    assign dataOut = stage[`WISC_SHAMT_BITS];

endmodule

`default_nettype wire

// File: verilog/aluCore.sv
// ALU with operand select, arithmetic, logic, compare, byte, bit reverse and result register
`timescale 1ns/1ns
`default_nettype none
`include "wisc_consts.svh"

module aluCore
    import wiscPkg::*;
(
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      opValid,
    input  logic                      illegal,
    input  aluOp_e                    aluOp,
    input  shiftOp_e                  shiftOp,
    input  logic                      useImm,
    input  logic [`WISC_WIDTH-1:0]    imm,
    input  logic [`WISC_REG_BITS-1:0] dstReg,
    input  logic [`WISC_WIDTH-1:0]    srcA,
    input  logic [`WISC_WIDTH-1:0]    srcB,
    output logic                      resultValid,
    output logic                      illegalInstr,
    output logic [`WISC_REG_BITS-1:0] resultReg,
    output logic [`WISC_WIDTH-1:0]    resultData
);

    logic [`WISC_WIDTH-1:0] opB;
    logic [`WISC_WIDTH:0]   sumWide;  // Carry in the top bit
    logic [`WISC_WIDTH-1:0] diff;
    logic [`WISC_WIDTH-1:0] shifted;
    logic [`WISC_WIDTH-1:0] bitRev;
    logic                   condBit;
    logic                   isCond;
    logic [`WISC_WIDTH-1:0] aluResult;

    assign opB     = useImm ? imm : srcB;
    assign sumWide = {1'b0, srcA} + {1'b0, opB};
    assign diff    = opB - srcA;    // B minus A
    assign bitRev  = {<<{srcA}};

    barrelShift shifter (
        .dataIn  (srcA),
        .shamt   (opB[`WISC_SHAMT_BITS-1:0]),
        .shiftOp (shiftOp),
        .dataOut (shifted)
    );

    always_comb begin
        condBit   = 1'b0;
        isCond    = 1'b0;
        aluResult = sumWide[`WISC_WIDTH-1:0];
        case (aluOp)
            AluAdd:   aluResult = sumWide[`WISC_WIDTH-1:0];
            AluSub:   aluResult = diff;
            AluXor:   aluResult = srcA ^ opB;
            AluAndn:  aluResult = srcA & ~opB;
            AluShift: aluResult = shifted;
            AluPassB: aluResult = opB;                    // LBI
            AluSlbi:  aluResult = (srcA << 8) | opB;
            AluBtr:   aluResult = bitRev;
            AluSeq: begin
                isCond  = 1'b1;
                condBit = (srcA == opB);
            end
            AluSlt: begin
                isCond  = 1'b1;
                condBit = $signed(srcA) < $signed(opB);
            end
            AluSle: begin
                isCond  = 1'b1;
                condBit = $signed(srcA) <= $signed(opB);
            end
            AluSco: begin
                isCond  = 1'b1;
                condBit = sumWide[`WISC_WIDTH];           // Carry out of A plus B
            end
            default: aluResult = '0;
        endcase
        if (isCond) begin
            aluResult = {{(`WISC_WIDTH-1){1'b0}}, condBit};
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultValid  <= 1'b0;
            illegalInstr <= 1'b0;
        end else begin
            resultValid  <= opValid;
            illegalInstr <= illegal;
        end
    end

    // Result payload, only loaded on a valid strobe
    always_ff @(posedge clk) begin
        if (opValid) begin
            resultReg  <= dstReg;
            resultData <= aluResult;
        end
    end

endmodule

`default_nettype wire

// File: verilog/wiscExec.sv
// Execute subsystem top level joining decoder, register file and ALU
`timescale 1ns/1ns
`default_nettype none
`include "wisc_consts.svh"

module wiscExec
    import wiscPkg::*;
(
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      instrValid,
    input  logic [`WISC_WIDTH-1:0]    instr,
    output logic                      resultValid,
    output logic                      illegalInstr,
    output logic [`WISC_REG_BITS-1:0] resultReg,
    output logic [`WISC_WIDTH-1:0]    resultData
);

    logic [`WISC_REG_BITS-1:0] rdAddrA;
    logic [`WISC_REG_BITS-1:0] rdAddrB;
    logic [`WISC_REG_BITS-1:0] dstReg;
    logic [`WISC_WIDTH-1:0]    imm;
    logic                      useImm;
    aluOp_e                    aluOp;
    shiftOp_e                  shiftOp;
    logic                      opValid;
    logic                      illegal;
    logic [`WISC_WIDTH-1:0]    rdDataA;
    logic [`WISC_WIDTH-1:0]    rdDataB;

    instrDecode decode (
        .instrValid (instrValid),
        .instr      (instr),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .dstReg     (dstReg),
        .imm        (imm),
        .useImm     (useImm),
        .aluOp      (aluOp),
        .shiftOp    (shiftOp),
        .opValid    (opValid),
        .illegal    (illegal)
    );

    // Write port fed back from the registered ALU result
    regFile regs (
        .clk     (clk),
        .arstN   (arstN),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (resultValid),
        .wrAddr  (resultReg),
        .wrData  (resultData)
    );

    aluCore alu (
        .clk          (clk),
        .arstN        (arstN),
        .opValid      (opValid),
        .illegal      (illegal),
        .aluOp        (aluOp),
        .shiftOp      (shiftOp),
        .useImm       (useImm),
        .imm          (imm),
        .dstReg       (dstReg),
        .srcA         (rdDataA),
        .srcB         (rdDataB),
        .resultValid  (resultValid),
        .illegalInstr (illegalInstr),
        .resultReg    (resultReg),
        .resultData   (resultData)
    );

endmodule

`default_nettype wire

// File: tests/tbClock.sv
// Testbench clock generator and power-on reset
`timescale 1ns/1ns
`default_nettype none

module tbClock (
    output logic clk,
    output logic arstN
);

    localparam int HalfPeriod = 50;  // 100 ns period

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (3) @(posedge clk);  // Three cycles in reset
        #5 arstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/wiscChecker.sv
// Reference register model, expected result function and output comparison
`timescale 1ns/1ns
`default_nettype none
`include "wisc_consts.svh"

module wiscChecker
    import wiscPkg::*;
(
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      instrValid,
    input  logic [`WISC_WIDTH-1:0]    instr,
    input  logic                      resultValid,
    input  logic                      illegalInstr,
    input  logic [`WISC_REG_BITS-1:0] resultReg,
    input  logic [`WISC_WIDTH-1:0]    resultData,
    output int                        valueErrs,
    output int                        strobeErrs,
    output int                        checks
);

    logic [15:0] model [`WISC_REGS];
    logic        expValid;
    logic        expIllegal;
    logic [2:0]  expReg;
    logic [15:0] expData;

    // Kind 00 SLL, 01 SRL, 10 ROL, 11 ROR
    function automatic logic [15:0] shiftRef(input logic [15:0] a, input logic [3:0] s,
                                             input logic [1:0] kind);
        logic [31:0] dbl;
        dbl = {a, a};  // Rotation as a window on the doubled word
        case (kind)
            2'b00:   return a << s;
            2'b01:   return a >> s;
            2'b10:   return dbl[31-s -: 16];
            default: return dbl[15+s -: 16];
        endcase
    endfunction

    // Returns {legal, destination, data}
    function automatic logic [19:0] refResult(input logic [15:0] ins);
        opcode_e     op;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm5s;
        logic [15:0] imm5z;
        logic [16:0] sum;
        logic [15:0] res;
        logic [2:0]  dst;
        logic        legal;
        op    = opcode_e'(ins[15:11]);
        a     = model[ins[10:8]];
        b     = model[ins[7:5]];
        imm5s = {{11{ins[4]}}, ins[4:0]};
        imm5z = {11'b0, ins[4:0]};
        sum   = {1'b0, a} + {1'b0, b};
        res   = '0;
        dst   = ins[4:2];  // R format unless changed below
        legal = 1'b1;
        case (op)
            OpAddi:  res = a + imm5s;
            OpSubi:  res = imm5s - a;
            OpXori:  res = a ^ imm5z;
            OpAndni: res = a & ~imm5z;
            OpSlli:  res = shiftRef(a, ins[3:0], 2'b00);
            OpSrli:  res = shiftRef(a, ins[3:0], 2'b01);
            OpRoli:  res = shiftRef(a, ins[3:0], 2'b10);
            OpRori:  res = shiftRef(a, ins[3:0], 2'b11);
            OpSlbi:  res = {a[7:0], ins[7:0]};
            OpLbi:   res = {{8{ins[7]}}, ins[7:0]};
            OpBtr: begin
                for (int i = 0; i < 16; i++) begin
                    res[i] = a[15-i];
                end
            end
            OpShiftReg: res = shiftRef(a, b[3:0], ins[1:0]);
            OpArithReg: begin
                case (ins[1:0])
                    2'b00:   res = a + b;
                    2'b01:   res = b - a;
                    2'b10:   res = a ^ b;
                    default: res = a & ~b;
                endcase
            end
            OpSeq:   res = {15'b0, a == b};
            OpSlt:   res = {15'b0, $signed(a) < $signed(b)};
            OpSle:   res = {15'b0, $signed(a) <= $signed(b)};
            OpSco:   res = {15'b0, sum[16]};
            default: legal = 1'b0;
        endcase
        if (op inside {OpAddi, OpSubi, OpXori, OpAndni, OpSlli, OpSrli, OpRoli, OpRori}) begin
            dst = ins[7:5];
        end else if (op inside {OpSlbi, OpLbi}) begin
            dst = ins[10:8];
        end
        return {legal, dst, res};
    endfunction

    // Outputs and inputs are both settled at the falling edge
    always @(negedge clk) begin
        logic [19:0] refOut;
        if (!arstN) begin
            for (int i = 0; i < `WISC_REGS; i++) begin
                model[i] = '0;
            end
            expValid   = 1'b0;
            expIllegal = 1'b0;
            expReg     = '0;
            expData    = '0;
            valueErrs  = 0;
            strobeErrs = 0;
            checks     = 0;
        end else begin
            if (resultValid !== expValid || illegalInstr !== expIllegal) begin
                strobeErrs++;
                $display("Strobe error at %0t: expected result %0b illegal %0b, got %b %b",
                         $time, expValid, expIllegal, resultValid, illegalInstr);
            end
            if (expValid && resultValid === 1'b1) begin
                checks++;
                if (resultReg !== expReg) begin
                    valueErrs++;
                    $display("FAIL %0t resultReg expected %0d got %0d",
                             $time, expReg, resultReg);
                end
                if (resultData !== expData) begin
                    valueErrs++;
                    $display("FAIL %0t resultData expected %h got %h",
                             $time, expData, resultData);
                end
            end
            if (expValid) begin
                model[expReg] = expData;  // Illegal ones leave the model alone
            end
            refOut     = refResult(instr);
            expValid   = instrValid && refOut[19];
            expIllegal = instrValid && !refOut[19];
            expReg     = refOut[18:16];
            expData    = refOut[15:0];
        end
    end

endmodule

`default_nettype wire

// File: tests/wiscExec_asserts.sv
// Concurrent assertions on the ALU result and illegal strobes, bound into aluCore
`timescale 1ns/1ns
`default_nettype none

module wiscExec_asserts (
    input logic clk,
    input logic arstN,
    input logic opValid,
    input logic illegal,
    input logic resultValid,
    input logic illegalInstr
);

    exclusiveOut: assert property (@(posedge clk) disable iff (!arstN)
        !(resultValid && illegalInstr))
        else $error("resultValid and illegalInstr high in the same cycle");

    validFollows: assert property (@(posedge clk) disable iff (!arstN)
        opValid |=> resultValid)
        else $error("resultValid missing one cycle after opValid");

    illegalFollows: assert property (@(posedge clk) disable iff (!arstN)
        illegal |=> illegalInstr)
        else $error("illegalInstr missing one cycle after illegal");

    // Outputs quiet while the reset is held
    quietInReset: assert property (@(posedge clk)
        !arstN |-> (!resultValid && !illegalInstr))
        else $error("Result strobe high during reset");

endmodule

bind aluCore wiscExec_asserts aluChecks (
    .clk          (clk),
    .arstN        (arstN),
    .opValid      (opValid),
    .illegal      (illegal),
    .resultValid  (resultValid),
    .illegalInstr (illegalInstr)
);

`default_nettype wire

// File: tests/wiscExec_tb.sv
// Testbench top with clock, DUT, checker and xorshift instruction stimulus
`timescale 1ns/1ns
`default_nettype none
`include "wisc_consts.svh"

module wiscExec_tb
    import wiscPkg::*;
();

    logic                      clk;
    logic                      arstN;
    logic                      instrValid;
    logic [`WISC_WIDTH-1:0]    instr;
    logic                      resultValid;
    logic                      illegalInstr;
    logic [`WISC_REG_BITS-1:0] resultReg;
    logic [`WISC_WIDTH-1:0]    resultData;
    int                        valueErrs;
    int                        strobeErrs;
    int                        checks;
    int                        waitTimeouts;
    logic [31:0]               rngState;

    tbClock clockGen (.clk(clk), .arstN(arstN));

    wiscExec wiscExec_inst (
        .clk          (clk),
        .arstN        (arstN),
        .instrValid   (instrValid),
        .instr        (instr),
        .resultValid  (resultValid),
        .illegalInstr (illegalInstr),
        .resultReg    (resultReg),
        .resultData   (resultData)
    );

    wiscChecker resultCheck (
        .clk          (clk),
        .arstN        (arstN),
        .instrValid   (instrValid),
        .instr        (instr),
        .resultValid  (resultValid),
        .illegalInstr (illegalInstr),
        .resultReg    (resultReg),
        .resultData   (resultData),
        .valueErrs    (valueErrs),
        .strobeErrs   (strobeErrs),
        .checks       (checks)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] randWord();
        rngState = xorshift(rngState);
        return rngState[15:0];
    endfunction

    function automatic logic [15:0] encI1(opcode_e op, logic [2:0] rs, logic [2:0] rd,
                                          logic [4:0] imm5);
        return {op, rs, rd, imm5};
    endfunction

    function automatic logic [15:0] encR(opcode_e op, logic [2:0] rs, logic [2:0] rt,
                                         logic [2:0] rd, logic [1:0] funct);
        return {op, rs, rt, rd, funct};
    endfunction

    function automatic logic [15:0] encI2(opcode_e op, logic [2:0] rs, logic [7:0] imm8);
        return {op, rs, imm8};
    endfunction

    task automatic issue(input logic [15:0] ins);
        @(posedge clk);
        #5;
        instrValid = 1'b1;
        instr      = ins;
    endtask

    // Drop the strobe, then wait for the last instruction's outcome
    task automatic drain();
        int n;
        @(posedge clk);
        #5;
        instrValid = 1'b0;
        n = 0;
        while (!(resultValid || illegalInstr) && n < 4) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (!(resultValid || illegalInstr)) begin
            waitTimeouts++;
            $display("Timeout at %0t: no result or illegal strobe came back", $time);
        end
    endtask

    task automatic exec(input logic [15:0] ins);
        issue(ins);
        drain();
    endtask

    // LBI sign extends the high byte, SLBI appends the low one
    task automatic loadReg(input logic [2:0] r, input logic [15:0] v);
        exec(encI2(OpLbi, r, v[15:8]));
        exec(encI2(OpSlbi, r, v[7:0]));
    endtask

    task automatic printCounts();
        $display("Checks %0d, value errors %0d, strobe errors %0d, wait timeouts %0d",
                 checks, valueErrs, strobeErrs, waitTimeouts);
    endtask

    initial begin
        int          n;
        logic [15:0] a;
        logic [15:0] pairA [4];
        logic [15:0] pairB [4];
        opcode_e     immOps [4];
        opcode_e     shOps [4];
        opcode_e     condOps [4];
        instrValid   = 1'b0;
        instr        = '0;
        rngState     = 32'h9a51;
        waitTimeouts = 0;
        immOps  = '{OpAddi, OpSubi, OpXori, OpAndni};
        shOps   = '{OpSlli, OpSrli, OpRoli, OpRori};
        condOps = '{OpSeq, OpSlt, OpSle, OpSco};
        pairA   = '{16'h1234, 16'h8001, 16'hF000, 16'h8000};  // Equal, negative, carry
        pairB   = '{16'h1234, 16'hFFFE, 16'h2000, 16'h8000};
        n = 0;
        while (arstN !== 1'b1 && n < 10) begin
            @(posedge clk);
            n++;
        end
        if (arstN !== 1'b1) begin
            waitTimeouts++;
            $display("Reset was never released");
        end

        exec(encI2(OpLbi, 3'd1, 8'h80));
        exec(encI2(OpSlbi, 3'd1, 8'h3C));

        repeat (12) begin
            loadReg(3'd2, randWord());
            loadReg(3'd3, randWord());
            for (int f = 0; f < 4; f++) begin
                a = randWord();
                exec(encR(OpArithReg, 3'd2, 3'd3, a[4:2], f[1:0]));
                exec(encI1(immOps[f], 3'd2, a[7:5], a[12:8]));
            end
        end

        loadReg(3'd4, randWord());
        for (int s = 0; s < 16; s++) begin
            a = randWord();
            for (int k = 0; k < 4; k++) begin
                exec(encI1(shOps[k], 3'd4, 3'd6, {a[k], s[3:0]}));  // Bit 4 is ignored
            end
            exec(encI2(OpLbi, 3'd5, {a[15:12], s[3:0]}));
            for (int k = 0; k < 4; k++) begin
                exec(encR(OpShiftReg, 3'd4, 3'd5, 3'd7, k[1:0]));
            end
        end

        for (int p = 0; p < 8; p++) begin
            loadReg(3'd2, (p < 4) ? pairA[p] : randWord());
            loadReg(3'd3, (p < 4) ? pairB[p] : randWord());
            for (int k = 0; k < 4; k++) begin
                exec(encR(condOps[k], 3'd2, 3'd3, 3'd1, 2'b00));
                exec(encR(condOps[k], 3'd3, 3'd2, 3'd6, 2'b00));
            end
            loadReg(3'd5, randWord());
            exec(encR(OpBtr, 3'd5, 3'd0, 3'd7, 2'b00));
        end

        // Dependent chain through the bypass, then random mixed traffic
        loadReg(3'd1, 16'h0010);
        repeat (4) issue(encI1(OpAddi, 3'd1, 3'd1, 5'd1));
        issue(encR(OpArithReg, 3'd1, 3'd1, 3'd2, 2'b00));
        issue(encR(OpArithReg, 3'd2, 3'd1, 3'd3, 2'b01));
        issue(encI1(OpSlli, 3'd3, 3'd3, 5'd2));
        issue(encR(OpSeq, 3'd3, 3'd3, 3'd4, 2'b00));
        drain();
        repeat (60) issue(randWord());
        drain();

        for (int op = 0; op < 32; op++) begin
            a = randWord();
            exec({op[4:0], a[10:0]});
        end
        for (int r = 0; r < 8; r++) begin
            exec(encI1(OpAddi, r[2:0], r[2:0], 5'd0));  // Read back each register
        end

        repeat (2) @(posedge clk);
        printCounts();
        if (valueErrs == 0 && strobeErrs == 0 && waitTimeouts == 0 && checks > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Whole-run limit
    initial begin
        #1_000_000;
        $display("Run did not finish within the time limit");
        printCounts();
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: wiscExec.f
+incdir+include
verilog/wiscPkg.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/barrelShift.sv
verilog/aluCore.sv
verilog/wiscExec.sv
tests/tbClock.sv
tests/wiscChecker.sv
tests/wiscExec_asserts.sv
tests/wiscExec_tb.sv

// File: Makefile
# Verilator build and regression run for the WISC execute subsystem

VERILATOR ?= verilator
TOP       ?= wiscExec_tb
FILELIST  ?= wiscExec.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/wisc_consts.svh

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
